//--- verilog/phold_pkg.sv
package phold_pkg;

   // timestamp and logical-process id widths
   localparam int TIME_WID = 16;
   localparam int NB_LPID  = 6;

   // event message as carried between cores and scheduler
   typedef struct packed {
      logic               cancel;
      logic [NB_LPID-1:0] lp_id;
      logic [TIME_WID-1:0] timestamp;
   } event_msg_t;

   // heap ordering key, inverted cancel flag makes anti-messages sort first
   typedef struct packed {
      logic [TIME_WID-1:0] timestamp;
      logic                not_cancel;
   } queue_key_t;

   typedef enum logic [1:0] {
      IDLE,
      INIT,
      RUNNING,
      FINISHED
   } run_state_t;

   // null message, dropped on the way into the queue
   localparam event_msg_t NULL_MSG = '{cancel: 1'b1, lp_id: '0, timestamp: '0};

   function automatic queue_key_t key_of(event_msg_t evt);
      queue_key_t key;
      key.timestamp  = evt.timestamp;
      key.not_cancel = ~evt.cancel;
      return key;
   endfunction

endpackage

//--- verilog/rr_arbiter.sv
`timescale 1ns/10ps

module rr_arbiter #(
   parameter int NUM_CORE = 4
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic [NUM_CORE-1:0] req,
   input  logic                advance,
   output logic [NUM_CORE-1:0] grant,
   output logic                grant_valid
);

   localparam int PTR_W = (NUM_CORE > 1) ? $clog2(NUM_CORE) : 1;

   logic [PTR_W-1:0] ptr;
   logic [PTR_W-1:0] grant_idx;

   // scan downwards so the request closest to ptr wins
   always_comb begin
      int idx;
      grant       = '0;
      grant_idx   = ptr;
      grant_valid = 1'b0;
      for (int k = NUM_CORE - 1; k >= 0; k--) begin
         idx = (int'(ptr) + k) % NUM_CORE;
         if (req[idx]) begin
            grant_idx   = PTR_W'(idx);
            grant_valid = 1'b1;
         end
      end
      grant[grant_idx] = grant_valid;
   end

   // pointer moves one past the index just served
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ptr <= '0;
      end else if (advance && grant_valid) begin
         ptr <= (grant_idx == PTR_W'(NUM_CORE - 1)) ? '0 : grant_idx + 1'b1;
      end
   end

   // a grant only ever goes to one requesting core
   assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(grant) && ((grant & ~req) == '0))
      else $error("rr_arbiter: bad grant %h for req %h", grant, req);

endmodule

//--- verilog/event_credit_fifo.sv
`timescale 1ns/10ps

module event_credit_fifo #(
   parameter int IN_DEPTH = 4
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  push,
   input  phold_pkg::event_msg_t push_evt,
   input  logic                  pop,
   output phold_pkg::event_msg_t head_evt,
   output logic                  not_empty,
   output logic                  credit
);

   localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
   localparam int CNT_W = $clog2(IN_DEPTH + 1);

   phold_pkg::event_msg_t mem [IN_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             full;
   logic             do_pop;

   assign not_empty = (count != '0);
   assign full      = (count == CNT_W'(IN_DEPTH));
   assign do_pop    = pop && not_empty;
   assign head_evt  = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= push_evt;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         credit <= 1'b0;
      end else begin
         // one credit back to the core for every freed slot
         credit <= do_pop;
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // core must never send without holding a credit
   assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
      else $error("event_credit_fifo: push while full, credit violation");

endmodule

//--- verilog/event_ingress.sv
`timescale 1ns/10ps

module event_ingress #(
   parameter int NUM_CORE = 4,
   parameter int IN_DEPTH = 4
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [NUM_CORE-1:0]   in_valid,
   input  phold_pkg::event_msg_t in_evt [NUM_CORE],
   output logic [NUM_CORE-1:0]   in_credit,
   input  logic                  init_valid,
   input  phold_pkg::event_msg_t init_evt,
   input  logic                  heap_full,
   output logic                  ins_valid,
   output phold_pkg::event_msg_t ins_evt
);

   phold_pkg::event_msg_t head_evt [NUM_CORE];
   phold_pkg::event_msg_t sel_evt;
   logic [NUM_CORE-1:0] not_empty;
   logic [NUM_CORE-1:0] grant;
   logic [NUM_CORE-1:0] pop;
   logic                grant_valid;
   logic                take_core;
   logic                is_null;

   for (genvar i = 0; i < NUM_CORE; i++) begin : g_fifo
      event_credit_fifo #(
         .IN_DEPTH (IN_DEPTH)
      ) fifo_inst (
         .clk       (clk),
         .rst_n     (rst_n),
         .push      (in_valid[i]),
         .push_evt  (in_evt[i]),
         .pop       (pop[i]),
         .head_evt  (head_evt[i]),
         .not_empty (not_empty[i]),
         .credit    (in_credit[i])
      );
   end

   rr_arbiter #(
      .NUM_CORE (NUM_CORE)
   ) arb_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .req         (not_empty),
      .advance     (take_core),
      .grant       (grant),
      .grant_valid (grant_valid)
   );

   // head of the granted buffer
   always_comb begin
      sel_evt = head_evt[0];
      for (int i = 0; i < NUM_CORE; i++) begin
         if (grant[i]) begin
            sel_evt = head_evt[i];
         end
      end
   end

   // init events win, core traffic stalls while the queue is full
   assign take_core = grant_valid && !init_valid && !heap_full;
   assign pop       = take_core ? grant : '0;
   assign is_null   = (sel_evt == phold_pkg::NULL_MSG);

   // null messages leave their buffer but never reach the queue
   assign ins_valid = init_valid || (take_core && !is_null);
   assign ins_evt   = init_valid ? init_evt : sel_evt;

endmodule

//--- verilog/event_heap.sv
`timescale 1ns/10ps

module event_heap #(
   parameter int QUEUE_DEPTH = 16
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  ins_valid,
   input  phold_pkg::event_msg_t ins_evt,
   input  logic                  rem,
   output logic                  head_valid,
   output phold_pkg::event_msg_t head_evt,
   output logic                  full
);

   localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

   phold_pkg::event_msg_t slot [QUEUE_DEPTH];
   phold_pkg::queue_key_t ins_key;
   logic [CNT_W-1:0]       count;
   logic [QUEUE_DEPTH-1:0] after_new;
   logic                   do_rem;

   assign ins_key  = phold_pkg::key_of(ins_evt);
   assign full     = (count == CNT_W'(QUEUE_DEPTH));
   assign head_evt = slot[0];

   // head is held back while an insert lands, so a remove waits
   assign head_valid = (count != '0) && !ins_valid;
   assign do_rem     = rem && !ins_valid && (count != '0);

   for (genvar i = 0; i < QUEUE_DEPTH; i++) begin : g_slot
      phold_pkg::event_msg_t shift_in;
      phold_pkg::event_msg_t shift_out;
      phold_pkg::queue_key_t slot_key;

      assign slot_key = phold_pkg::key_of(slot[i]);

      // strictly greater keys move back, equal keys keep arrival order
      assign after_new[i] = (CNT_W'(i) >= count) || (slot_key > ins_key);

      if (i == 0) begin : g_first
         assign shift_in = ins_evt;
      end else begin : g_rest
         assign shift_in = after_new[i-1] ? slot[i-1] : ins_evt;
      end

      if (i == QUEUE_DEPTH - 1) begin : g_last
         assign shift_out = slot[i];
      end else begin : g_inner
         assign shift_out = slot[i+1];
      end

      always_ff @(posedge clk) begin
         if (ins_valid && after_new[i]) begin
            slot[i] <= shift_in;
         end else if (do_rem) begin
            slot[i] <= shift_out;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count <= '0;
      end else if (ins_valid) begin
         count <= count + 1'b1;
      end else if (do_rem) begin
         count <= count - 1'b1;
      end
   end

   // ingress backs off on full, init never overfills
   assert property (@(posedge clk) disable iff (!rst_n) ins_valid |-> !full)
      else $error("event_heap: insert while full");

   // dispatch only removes a head it was shown
   assert property (@(posedge clk) disable iff (!rst_n) rem |-> count != '0)
      else $error("event_heap: remove while empty");

endmodule

//--- verilog/sim_control.sv
`timescale 1ns/10ps

module sim_control #(
   parameter int QUEUE_DEPTH = 16
) (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic [7:0]                       num_init_events,
   input  logic [phold_pkg::NB_LPID-1:0]    lp_mask,
   input  logic [phold_pkg::TIME_WID-1:0]   sim_end,
   input  logic                             head_valid,
   input  phold_pkg::event_msg_t            head_evt,
   output logic                             init_valid,
   output phold_pkg::event_msg_t            init_evt,
   output logic                             running,
   output logic [phold_pkg::TIME_WID-1:0]   gvt,
   output logic                             done
);

   phold_pkg::run_state_t state;
   phold_pkg::run_state_t state_nxt;
   logic [7:0] init_cnt;
   logic       last_init;
   logic       past_end;

   assign past_end   = (gvt > sim_end);
   assign init_valid = (state == phold_pkg::INIT) && (init_cnt < num_init_events);
   assign last_init  = ({1'b0, init_cnt} + 9'd1) >= {1'b0, num_init_events};

   // dispatch stops as soon as gvt passes the end time
   assign running = (state == phold_pkg::RUNNING) && !past_end;

   // seed events at time 0 with targets taken from the counter
   assign init_evt.cancel    = 1'b0;
   assign init_evt.lp_id     = init_cnt[phold_pkg::NB_LPID-1:0] & lp_mask;
   assign init_evt.timestamp = '0;

   always_comb begin
      state_nxt = state;
      case (state)
         phold_pkg::IDLE:    state_nxt = phold_pkg::INIT;
         phold_pkg::INIT:    if (last_init) state_nxt = phold_pkg::RUNNING;
         phold_pkg::RUNNING: if (past_end) state_nxt = phold_pkg::FINISHED;
         default:            state_nxt = state;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= phold_pkg::IDLE;
         init_cnt <= '0;
         gvt      <= '0;
         done     <= 1'b0;
      end else begin
         state <= state_nxt;
         if (init_valid) begin
            init_cnt <= init_cnt + 1'b1;
         end
         // gvt follows the queue head upwards only while the run is live
         if (running && head_valid && head_evt.timestamp > gvt) begin
            gvt <= head_evt.timestamp;
         end
         // sticky until reset
         if (state == phold_pkg::RUNNING && past_end) begin
            done <= 1'b1;
         end
      end
   end

   // all seed events have to fit in the queue at once
   assert property (@(posedge clk) disable iff (!rst_n)
      state == phold_pkg::INIT |-> num_init_events <= QUEUE_DEPTH)
      else $error("sim_control: num_init_events %0d exceeds queue", num_init_events);

endmodule

//--- verilog/event_dispatch.sv
`timescale 1ns/10ps

module event_dispatch #(
   parameter int NUM_CORE    = 4,
   parameter int OUT_CREDITS = 2
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  running,
   input  logic                  head_valid,
   input  phold_pkg::event_msg_t head_evt,
   output logic                  rem,
   output logic [NUM_CORE-1:0]   out_valid,
   output phold_pkg::event_msg_t out_evt,
   input  logic [NUM_CORE-1:0]   out_credit
);

   localparam int CW = $clog2(OUT_CREDITS + 1);

   logic [CW-1:0]       credit_cnt [NUM_CORE];
   logic [NUM_CORE-1:0] has_credit;
   logic [NUM_CORE-1:0] grant;
   logic                grant_valid;

   rr_arbiter #(
      .NUM_CORE (NUM_CORE)
   ) arb_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .req         (has_credit),
      .advance     (rem),
      .grant       (grant),
      .grant_valid (grant_valid)
   );

   // pull the head when some core can take it
   assign rem = running && head_valid && grant_valid;

   for (genvar i = 0; i < NUM_CORE; i++) begin : g_credit
      assign has_credit[i] = (credit_cnt[i] != '0);

      always_ff @(posedge clk or negedge rst_n) begin
         if (!rst_n) begin
            credit_cnt[i] <= CW'(OUT_CREDITS);
         end else begin
            case ({rem && grant[i], out_credit[i]})
               2'b10:   credit_cnt[i] <= credit_cnt[i] - 1'b1;
               2'b01:   credit_cnt[i] <= credit_cnt[i] + 1'b1;
               default: credit_cnt[i] <= credit_cnt[i];
            endcase
         end
      end

      // a core returns no more credits than it was handed events
      assert property (@(posedge clk) disable iff (!rst_n)
         out_credit[i] |-> credit_cnt[i] != CW'(OUT_CREDITS))
         else $error("event_dispatch: core %0d returned an extra credit", i);
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= '0;
      end else begin
         out_valid <= rem ? grant : '0;
      end
   end

   always_ff @(posedge clk) begin
      if (rem) begin
         out_evt <= head_evt;
      end
   end

endmodule

//--- verilog/phold_sched.sv
`timescale 1ns/10ps

module phold_sched #(
   parameter int NUM_CORE    = 4,
   parameter int IN_DEPTH    = 4,
   parameter int OUT_CREDITS = 2,
   parameter int QUEUE_DEPTH = 16
) (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic [phold_pkg::TIME_WID-1:0] sim_end,
   input  logic [7:0]                     num_init_events,
   input  logic [phold_pkg::NB_LPID-1:0]  lp_mask,
   input  logic [NUM_CORE-1:0]            in_valid,
   input  phold_pkg::event_msg_t          in_evt [NUM_CORE],
   output logic [NUM_CORE-1:0]            in_credit,
   output logic [NUM_CORE-1:0]            out_valid,
   output phold_pkg::event_msg_t          out_evt,
   input  logic [NUM_CORE-1:0]            out_credit,
   output logic [phold_pkg::TIME_WID-1:0] gvt,
   output logic                           done
);

   phold_pkg::event_msg_t ins_evt;
   phold_pkg::event_msg_t head_evt;
   phold_pkg::event_msg_t init_evt;
   logic ins_valid;
   logic heap_full;
   logic head_valid;
   logic rem;
   logic init_valid;
   logic running;

   event_ingress #(
      .NUM_CORE (NUM_CORE),
      .IN_DEPTH (IN_DEPTH)
   ) ingress_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .in_evt     (in_evt),
      .in_credit  (in_credit),
      .init_valid (init_valid),
      .init_evt   (init_evt),
      .heap_full  (heap_full),
      .ins_valid  (ins_valid),
      .ins_evt    (ins_evt)
   );

   event_heap #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) heap_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .ins_valid  (ins_valid),
      .ins_evt    (ins_evt),
      .rem        (rem),
      .head_valid (head_valid),
      .head_evt   (head_evt),
      .full       (heap_full)
   );

   sim_control #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) control_inst (
      .clk             (clk),
      .rst_n           (rst_n),
      .num_init_events (num_init_events),
      .lp_mask         (lp_mask),
      .sim_end         (sim_end),
      .head_valid      (head_valid),
      .head_evt        (head_evt),
      .init_valid      (init_valid),
      .init_evt        (init_evt),
      .running         (running),
      .gvt             (gvt),
      .done            (done)
   );

   event_dispatch #(
      .NUM_CORE    (NUM_CORE),
      .OUT_CREDITS (OUT_CREDITS)
   ) dispatch_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .running    (running),
      .head_valid (head_valid),
      .head_evt   (head_evt),
      .rem        (rem),
      .out_valid  (out_valid),
      .out_evt    (out_evt),
      .out_credit (out_credit)
   );

endmodule

//--- tb/tb_phold_sched.sv
`timescale 1ns/10ps

module tb_phold_sched;

   localparam int NUM_CORE    = 4;
   localparam int IN_DEPTH    = 4;
   localparam int OUT_CREDITS = 2;
   localparam int QUEUE_DEPTH = 16;
   localparam int LP_W        = phold_pkg::NB_LPID;
   localparam int TS_W        = phold_pkg::TIME_WID;

   logic                  clk;
   logic                  rst_n;
   logic [TS_W-1:0]       sim_end;
   logic [7:0]            num_init_events;
   logic [LP_W-1:0]       lp_mask;
   logic [NUM_CORE-1:0]   in_valid;
   phold_pkg::event_msg_t in_evt [NUM_CORE];
   logic [NUM_CORE-1:0]   in_credit;
   logic [NUM_CORE-1:0]   out_valid;
   phold_pkg::event_msg_t out_evt;
   logic [NUM_CORE-1:0]   out_credit;
   logic [TS_W-1:0]       gvt;
   logic                  done;

   // golden words: header, injected {core, event}, expected count and order
   logic [31:0] golden [64];
   int n_inject;
   int n_expect;
   int limit_cycles = 0;

   // core-side bookkeeping
   int sent        [NUM_CORE] = '{default: 0};
   int credit_back [NUM_CORE] = '{default: 0};
   int received    [NUM_CORE] = '{default: 0};
   int returned    [NUM_CORE] = '{default: 0};
   int n_out      = 0;
   int cycle      = 0;
   int end_cycle  = -1;
   int done_cycle = -1;
   logic            release_credits = 1'b0;
   logic [TS_W-1:0] max_ts   = '0;
   logic [TS_W-1:0] prev_gvt = '0;
   logic [TS_W:0]   last_key = '0;

   initial clk = 1'b0;
   always #50 clk = ~clk;

   phold_sched #(
      .NUM_CORE    (NUM_CORE),
      .IN_DEPTH    (IN_DEPTH),
      .OUT_CREDITS (OUT_CREDITS),
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) phold_sched_inst (
      .clk             (clk),
      .rst_n           (rst_n),
      .sim_end         (sim_end),
      .num_init_events (num_init_events),
      .lp_mask         (lp_mask),
      .in_valid        (in_valid),
      .in_evt          (in_evt),
      .in_credit       (in_credit),
      .out_valid       (out_valid),
      .out_evt         (out_evt),
      .out_credit      (out_credit),
      .gvt             (gvt),
      .done            (done)
   );

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("Checks failed");
      $fatal(1, "run stopped at first failure");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected) begin
         fail_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, expected));
      end
   endtask

   // core model returns one out_credit per received event once released
   initial begin : return_credits
      out_credit = '0;
      forever begin
         @(posedge clk);
         #1;
         for (int i = 0; i < NUM_CORE; i++) begin
            out_credit[i] = release_credits && (received[i] > returned[i]);
            if (out_credit[i]) begin
               returned[i]++;
            end
         end
      end
   end

   always @(negedge clk) begin : watch_outputs
      phold_pkg::event_msg_t seed_evt;
      logic [TS_W:0] key;
      int c;
      if (rst_n) begin
         cycle++;
         for (int i = 0; i < NUM_CORE; i++) begin
            if (in_credit[i]) begin
               credit_back[i]++;
               if (credit_back[i] > sent[i]) begin
                  fail_run($sformatf("core %0d got an in_credit it never paid for", i));
               end
            end
         end
         if (gvt < prev_gvt) begin
            fail_run("gvt moved backwards");
         end
         if (out_valid != '0) begin
            check_value("out_valid ones", 32'($countones(out_valid)), 32'd1);
            if (end_cycle >= 0) begin
               fail_run("an event was dispatched after gvt passed sim_end");
            end
            c = 0;
            for (int i = 0; i < NUM_CORE; i++) begin
               if (out_valid[i]) begin
                  c = i;
               end
            end
            received[c]++;
            if (received[c] - returned[c] > OUT_CREDITS) begin
               fail_run($sformatf("core %0d holds more events than its credits", c));
            end
            if (n_out < int'(num_init_events)) begin
               // seed i targets lp i under lp_mask at time 0
               seed_evt       = '0;
               seed_evt.lp_id = LP_W'(n_out) & lp_mask;
               check_value("out_evt", 32'(out_evt), 32'(seed_evt));
            end else if (n_out - int'(num_init_events) < n_expect) begin
               check_value("out_evt", 32'(out_evt),
                           32'(golden[5 + n_inject + n_out - int'(num_init_events)][22:0]));
            end else begin
               fail_run("more events dispatched than the golden list holds");
            end
            // ascending timestamps, cancel first on a tie
            key = {out_evt.timestamp, ~out_evt.cancel};
            if (key < last_key) begin
               fail_run("dispatch order broke timestamp priority");
            end
            last_key = key;
            if (out_evt.timestamp > max_ts) begin
               max_ts = out_evt.timestamp;
            end
            check_value("gvt", 32'(gvt), 32'(max_ts));
            n_out++;
         end
         if (end_cycle < 0 && gvt > sim_end) begin
            end_cycle = cycle;
         end
         if (done && done_cycle < 0) begin
            done_cycle = cycle;
            check_value("done rise cycle", 32'(done_cycle), 32'(end_cycle + 1));
         end
         if (done_cycle >= 0) begin
            check_value("done", 32'(done), 32'd1);
         end
         prev_gvt = gvt;
      end
   end

   initial begin : watchdog
      wait (limit_cycles > 0);
      repeat (limit_cycles) begin
         @(posedge clk);
      end
      fail_run($sformatf("timeout, run did not finish within %0d cycles", limit_cycles));
   end

   initial begin : run_test
      phold_pkg::event_msg_t evt;
      int core;
      int gap;
      void'($urandom(56));
      $readmemh("tb/phold_golden.txt", golden);
      num_init_events = golden[0][7:0];
      lp_mask         = golden[1][LP_W-1:0];
      sim_end         = golden[2][TS_W-1:0];
      n_inject        = int'(golden[3]);
      n_expect        = int'(golden[4 + n_inject]);
      limit_cycles    = (int'(num_init_events) + n_inject + n_expect) * 40 + 200;
      rst_n    = 1'b0;
      in_valid = '0;
      for (int i = 0; i < NUM_CORE; i++) begin
         in_evt[i] = '0;
      end
      repeat (16) begin
         @(posedge clk);
      end
      #1;
      rst_n = 1'b1;

      // seeds use up every output credit
      wait (n_out == int'(num_init_events));
      @(posedge clk);
      #1;

      // batch goes in one event per cycle at most, so arrival order is injection order
      for (int idx = 0; idx < n_inject; idx++) begin
         core = int'(golden[4 + idx][31:24]);
         evt  = golden[4 + idx][22:0];
         gap  = int'($urandom % 3);
         repeat (gap) begin
            @(posedge clk);
            #1;
         end
         while (IN_DEPTH - sent[core] + credit_back[core] == 0) begin
            @(posedge clk);
            #1;
         end
         in_valid[core] = 1'b1;
         in_evt[core]   = evt;
         sent[core]++;
         @(posedge clk);
         #1;
         in_valid[core] = 1'b0;
      end

      // wait until every input buffer has drained into the queue
      for (int i = 0; i < NUM_CORE; i++) begin
         while (credit_back[i] != sent[i]) begin
            @(posedge clk);
         end
      end
      check_value("dispatched before release", 32'(n_out), 32'(num_init_events));
      release_credits = 1'b1;

      wait (done);
      repeat (20) begin
         @(posedge clk);
      end
      check_value("dispatched total", 32'(n_out), 32'(int'(num_init_events) + n_expect));
      for (int i = 0; i < NUM_CORE; i++) begin
         check_value($sformatf("in_credit count core %0d", i),
                     32'(credit_back[i]), 32'(sent[i]));
      end
      check_value("gvt final", 32'(gvt), 32'(golden[4 + n_inject + n_expect][TS_W-1:0]));
      $display("All checks passed");
      $finish;
   end

endmodule

//--- tb/phold_golden.txt
// header: num_init_events, lp_mask, sim_end, number of injected events
08
0d
0050
0e
// injected: core in bits 31:24, event {cancel, lp_id, timestamp} in bits 22:0
00030010
01050030
02450030
03400000
01070020
00090020
02020048
03010010
00400000
01040060
02060070
03480048
000b0050
01400000
// expected count, then dispatch order after the seeds
0a
00030010
00010010
00070020
00090020
00450030
00050030
00480048
00020048
000b0050
00040060

//--- tb.f
verilog/phold_pkg.sv
verilog/rr_arbiter.sv
verilog/event_credit_fifo.sv
verilog/event_ingress.sv
verilog/event_heap.sv
verilog/sim_control.sv
verilog/event_dispatch.sv
verilog/phold_sched.sv
tb/tb_phold_sched.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_phold_sched
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/10ps
PASS_MSG  ?= All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
